// File: Makefile
# Verilator build for the MII receive path

TOP = eth_rx_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -qx ">>> PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+.
eth_rx_pkg.sv
eth_rx_byte_if.sv
eth_rx_nibble_decode.sv
eth_rx_frame_check.sv
eth_rx_frame_buffer.sv
eth_rx_top.sv
eth_rx_assert.sv
eth_rx_tb.sv

// File: eth_rx_assert.sv
`timescale 1ns/1ps

module eth_rx_assert (
   input logic       RX_CLK,
   input logic       ETH_PHY_RESETN,
   input logic       rcv_ack,
   input logic       data_rcvd,
   input logic [7:0] drop_count,
   input logic       chk_valid,
   input logic       chk_stop
);

   // Raised by any failing assertion below
   logic violation = 1'b0;

   // Held frame is released only by the host
   held_until_ack: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      (data_rcvd && !rcv_ack) |=> data_rcvd)
      else begin
         $error("data_rcvd dropped without rcv_ack");
         violation = 1'b1;
      end

   stop_not_with_byte: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      !(chk_valid && chk_stop))
      else begin
         $error("chk_bus valid and stop high together");
         violation = 1'b1;
      end

   drops_monotonic: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      drop_count >= $past(drop_count))
      else begin
         $error("drop_count decreased");
         violation = 1'b1;
      end

endmodule

bind eth_rx_top eth_rx_assert bus_checks (
   .RX_CLK         (RX_CLK),
   .ETH_PHY_RESETN (ETH_PHY_RESETN),
   .rcv_ack        (rcv_ack),
   .data_rcvd      (data_rcvd),
   .drop_count     (drop_count),
   .chk_valid      (chk_bus.valid),
   .chk_stop       (chk_bus.stop)
);

// File: eth_rx_byte_if.sv
`timescale 1ns/1ps

interface eth_rx_byte_if;
   import eth_rx_pkg::*;

   // Byte and its one-cycle strobe
   rx_byte_t data;
   logic     valid;
   // First byte after the SFD
   logic     start;
   // End of frame, never together with valid
   logic     stop;

   modport sender (
      output data,
      output valid,
      output start,
      output stop
   );

   modport receiver (
      input data,
      input valid,
      input start,
      input stop
   );

endinterface

// File: eth_rx_frame_buffer.sv
`timescale 1ns/1ps

`include "eth_rx_settings.svh"

module eth_rx_frame_buffer (
   input  logic                            RX_CLK,
   input  logic                            ETH_PHY_RESETN,
   eth_rx_byte_if.receiver                 bus,
   input  eth_rx_pkg::verdict_t            verdict,
   input  logic                            rcv_ack,
   input  logic [`ETH_RX_BUF_ADDR_W-1:0]   rd_addr,
   output eth_rx_pkg::rx_byte_t            rd_data,
   output logic                            data_rcvd,
   output eth_rx_pkg::frame_size_t         rcv_size,
   output logic [7:0]                      drop_count
);
   import eth_rx_pkg::*;

   localparam int depth = 1 << `ETH_RX_BUF_ADDR_W;

   rx_byte_t    mem [depth];
   frame_size_t wr_ptr;
   frame_size_t wr_addr;
   logic        wr_en;
   // Current frame started while the buffer was free
   logic        storing;

   // A held frame blocks any frame that starts before the ack
   assign wr_en   = bus.valid && (bus.start ? !data_rcvd : storing);
   assign wr_addr = bus.start ? '0 : wr_ptr;

   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         mem[wr_addr] <= bus.data;
      end
   end

   assign rd_data = mem[rd_addr];

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         wr_ptr     <= '0;
         storing    <= 1'b0;
         data_rcvd  <= 1'b0;
         rcv_size   <= '0;
         drop_count <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_addr + 1'b1;
         end

         if (bus.start) begin
            storing <= !data_rcvd;
         end else if (bus.stop) begin
            storing <= 1'b0;
         end

         // Frames that fail a check are abandoned here
         if (bus.stop && storing && verdict == GOOD) begin
            data_rcvd <= 1'b1;
            rcv_size  <= wr_ptr;
         end else if (rcv_ack) begin
            data_rcvd <= 1'b0;
         end

         // Frame ended while the host still owns the buffer
         if (bus.stop && data_rcvd && drop_count != 8'hFF) begin
            drop_count <= drop_count + 8'd1;
         end
      end
   end

endmodule

// File: eth_rx_frame_check.sv
`timescale 1ns/1ps

`include "eth_rx_settings.svh"

module eth_rx_frame_check (
   input  logic                RX_CLK,
   input  logic                ETH_PHY_RESETN,
   eth_rx_byte_if.receiver     in_bus,
   eth_rx_byte_if.sender       out_bus,
   output eth_rx_pkg::verdict_t verdict
);
   import eth_rx_pkg::*;

   localparam logic [47:0] station_mac = `ETH_RX_MAC_ADDR;

   frame_size_t byte_cnt;
   frame_size_t byte_idx;
   rx_byte_t    mac_byte;
   logic        mac_hit;
   logic        bcast_hit;
   logic        uc_match;
   logic        bc_match;
   logic [31:0] crc;
   logic [31:0] crc_msb_first;

   // One byte through the reflected CRC-32
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input rx_byte_t d);
      logic [31:0] c;
      c = crc_in ^ {24'd0, d};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ `ETH_RX_CRC_POLY) : (c >> 1);
      end
      return c;
   endfunction

   // Position of the byte now on in_bus
   assign byte_idx = in_bus.start ? '0 : byte_cnt;

   // Expected destination byte at this position
   always_comb begin
      case (byte_idx[2:0])
         3'd0:    mac_byte = station_mac[47:40];
         3'd1:    mac_byte = station_mac[39:32];
         3'd2:    mac_byte = station_mac[31:24];
         3'd3:    mac_byte = station_mac[23:16];
         3'd4:    mac_byte = station_mac[15:8];
         default: mac_byte = station_mac[7:0];
      endcase
   end

   assign mac_hit   = (in_bus.data == mac_byte);
   assign bcast_hit = (in_bus.data == 8'hFF);

   // Residue constant is MSB-first, the register is reflected
   assign crc_msb_first = {<<{crc}};

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         out_bus.valid <= 1'b0;
         out_bus.start <= 1'b0;
         out_bus.stop  <= 1'b0;
         byte_cnt      <= '0;
         uc_match      <= 1'b0;
         bc_match      <= 1'b0;
         crc           <= 32'hFFFF_FFFF;
         verdict       <= RUNT;
      end else begin
         out_bus.valid <= in_bus.valid;
         out_bus.start <= in_bus.start;
         out_bus.stop  <= in_bus.stop;
         if (in_bus.valid) begin
            // Count saturates so an oversized frame never looks short
            byte_cnt <= (byte_idx == '1) ? byte_idx : byte_idx + 1'b1;
            crc      <= crc32_byte(in_bus.start ? 32'hFFFF_FFFF : crc, in_bus.data);
            if (in_bus.start) begin
               uc_match <= mac_hit;
               bc_match <= bcast_hit;
            end else if (byte_idx < 6) begin
               uc_match <= uc_match & mac_hit;
               bc_match <= bc_match & bcast_hit;
            end
         end
         if (in_bus.stop) begin
            if (byte_cnt < `ETH_RX_MIN_LEN) begin
               verdict <= RUNT;
            end else if (!uc_match && !bc_match) begin
               verdict <= NOT_OURS;
            end else if (crc_msb_first != `ETH_RX_CRC_RESIDUE) begin
               verdict <= BAD_CRC;
            end else begin
               verdict <= GOOD;
            end
            // A stop with no bytes then reads as a runt
            byte_cnt <= '0;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      out_bus.data <= in_bus.data;
   end

endmodule

// File: eth_rx_nibble_decode.sv
`timescale 1ns/1ps

module eth_rx_nibble_decode (
   input  logic                RX_CLK,
   input  logic                ETH_PHY_RESETN,
   input  logic [3:0]          rx_data,
   input  logic                rx_dv,
   output logic                phy_dv_detected,
   eth_rx_byte_if.sender       bus
);
   import eth_rx_pkg::*;

   rx_state_t  state;
   logic [3:0] lo_nib;
   // Next byte out is the first of the frame
   logic       first;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state           <= IDLE;
         first           <= 1'b0;
         bus.valid       <= 1'b0;
         bus.start       <= 1'b0;
         bus.stop        <= 1'b0;
         phy_dv_detected <= 1'b0;
      end else begin
         bus.valid <= 1'b0;
         bus.start <= 1'b0;
         bus.stop  <= 1'b0;
         if (rx_dv) begin
            phy_dv_detected <= 1'b1;
         end
         case (state)
            IDLE: begin
               if (rx_dv && rx_data == 4'h5) begin
                  state <= PREAMBLE;
               end
            end
            PREAMBLE: begin
               // Dropout before the SFD ends the attempt quietly
               if (!rx_dv || (rx_data != 4'h5 && rx_data != 4'hD)) begin
                  state <= IDLE;
               end else if (rx_data == 4'hD) begin
                  state <= DATA_LO;
                  first <= 1'b1;
               end
            end
            DATA_LO: begin
               if (!rx_dv) begin
                  bus.stop <= 1'b1;
                  state    <= IDLE;
               end else begin
                  state <= DATA_HI;
               end
            end
            default: begin
               // An odd trailing nibble is simply lost
               if (!rx_dv) begin
                  bus.stop <= 1'b1;
                  state    <= IDLE;
               end else begin
                  bus.valid <= 1'b1;
                  bus.start <= first;
                  first     <= 1'b0;
                  state     <= DATA_LO;
               end
            end
         endcase
      end
   end

   // Low nibble arrives first on MII
   always_ff @(posedge RX_CLK) begin
      if (state == DATA_LO) begin
         lo_nib <= rx_data;
      end
      if (state == DATA_HI) begin
         bus.data <= {rx_data, lo_nib};
      end
   end

endmodule

// File: eth_rx_pkg.sv
`include "eth_rx_settings.svh"

package eth_rx_pkg;

   // Receive decoder states
   typedef enum logic [1:0] {
      IDLE,
      PREAMBLE,
      DATA_LO,
      DATA_HI
   } rx_state_t;

   // Outcome of the frame checks, in priority order
   // RUNT beats NOT_OURS beats BAD_CRC
   typedef enum logic [1:0] {
      GOOD,
      BAD_CRC,
      NOT_OURS,
      RUNT
   } verdict_t;

   // One received byte
   typedef logic [7:0] rx_byte_t;

   // Byte count within a frame
   // Same width as a buffer address
   typedef logic [`ETH_RX_BUF_ADDR_W-1:0] frame_size_t;

endpackage

// File: eth_rx_settings.svh
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

// Station address, first byte on the wire is the top byte
`define ETH_RX_MAC_ADDR 48'h02_00_5E_10_20_30

// Receive buffer address width
// 2048 bytes hold one maximum-size 1518 byte frame
`define ETH_RX_BUF_ADDR_W 11

// Smallest legal frame in bytes, FCS included
`define ETH_RX_MIN_LEN 64

// CRC register after a correct frame and its FCS
// Given in MSB-first bit order
`define ETH_RX_CRC_RESIDUE 32'hC704DD7B

// Reflected CRC-32 polynomial
`define ETH_RX_CRC_POLY 32'hEDB88320

`endif

// File: eth_rx_tb.sv
`timescale 1ns/1ps

`include "eth_rx_settings.svh"

module eth_rx_tb;
   import eth_rx_pkg::*;

   typedef logic [7:0] byte_q_t[$];

   // Frame lengths of all tests set the watchdog budget
   localparam int frame_bytes_total = 100 + 100 + 80 + 80 + 60 + 64 + 70 + 74 + 78 + 90;
   localparam int frame_count       = 10;
   localparam int total_nibbles     = 2 * frame_bytes_total + 16 * frame_count + 6;
   localparam longint watchdog_ns   = 20 * total_nibbles * 40;

   localparam logic [47:0] own_mac   = `ETH_RX_MAC_ADDR;
   localparam logic [47:0] bcast_mac = 48'hFF_FF_FF_FF_FF_FF;
   localparam logic [47:0] other_mac = 48'h02_00_5E_10_20_31;

   logic                          RX_CLK;
   logic                          ETH_PHY_RESETN;
   logic [3:0]                    rx_data;
   logic                          rx_dv;
   logic                          rcv_ack;
   logic [`ETH_RX_BUF_ADDR_W-1:0] rd_addr;
   rx_byte_t                      rd_data;
   logic                          data_rcvd;
   frame_size_t                   rcv_size;
   logic [7:0]                    drop_count;
   logic                          phy_dv_detected;

   logic [31:0] lfsr = 32'h89875bae;
   byte_q_t     frame_q;

   eth_rx_top UUT (
      .RX_CLK          (RX_CLK),
      .ETH_PHY_RESETN  (ETH_PHY_RESETN),
      .rx_data         (rx_data),
      .rx_dv           (rx_dv),
      .rcv_ack         (rcv_ack),
      .rd_addr         (rd_addr),
      .rd_data         (rd_data),
      .data_rcvd       (data_rcvd),
      .rcv_size        (rcv_size),
      .drop_count      (drop_count),
      .phy_dv_detected (phy_dv_detected)
   );

   initial RX_CLK = 1'b0;
   always #20 RX_CLK = ~RX_CLK;

   task automatic stop_with_failure();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_failure(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      stop_with_failure();
   endtask

   task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
         stop_with_failure();
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_byte(output logic [7:0] b);
      for (int k = 0; k < 8; k++) begin
         lfsr = lfsr_step(lfsr);
         b[k] = lfsr[0];
      end
   endtask

   // Bit-serial CRC-32 taking the LSB of each byte first
   function automatic logic [31:0] fcs_of(input byte_q_t q);
      logic [31:0] crc;
      logic        fb;
      crc = 32'hFFFF_FFFF;
      foreach (q[i]) begin
         for (int k = 0; k < 8; k++) begin
            fb  = crc[0] ^ q[i][k];
            crc = crc >> 1;
            if (fb) begin
               crc = crc ^ 32'hEDB8_8320;
            end
         end
      end
      return ~crc;
   endfunction

   // Total length len includes the 4 FCS bytes
   task automatic build_frame(input logic [47:0] dst, input int len);
      logic [47:0] src;
      logic [31:0] fcs;
      logic [7:0]  b;
      src = 48'h02_11_22_33_44_55;
      frame_q.delete();
      for (int i = 5; i >= 0; i--) begin
         frame_q.push_back(dst[8*i +: 8]);
      end
      for (int i = 5; i >= 0; i--) begin
         frame_q.push_back(src[8*i +: 8]);
      end
      frame_q.push_back(8'h08);
      frame_q.push_back(8'h00);
      for (int i = 0; i < len - 18; i++) begin
         random_byte(b);
         frame_q.push_back(b);
      end
      fcs = fcs_of(frame_q);
      for (int i = 0; i < 4; i++) begin
         frame_q.push_back(fcs[8*i +: 8]);
      end
   endtask

   task automatic drive_nibble(input logic [3:0] n);
      @(negedge RX_CLK);
      rx_data = n;
      rx_dv   = 1'b1;
   endtask

   task automatic send_frame();
      repeat (15) drive_nibble(4'h5);
      drive_nibble(4'hD);
      foreach (frame_q[i]) begin
         drive_nibble(frame_q[i][3:0]);
         drive_nibble(frame_q[i][7:4]);
      end
      @(negedge RX_CLK);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
   endtask

   task automatic wait_for_rcvd();
      int n;
      n = 0;
      while (!data_rcvd && n < 8) begin
         @(negedge RX_CLK);
         n++;
      end
      if (!data_rcvd) begin
         report_failure("data_rcvd never rose");
      end
   endtask

   task automatic expect_no_frame();
      repeat (8) begin
         @(negedge RX_CLK);
         check("data_rcvd", 32'(data_rcvd), 32'd0);
      end
   endtask

   task automatic check_contents(input byte_q_t q);
      foreach (q[i]) begin
         @(negedge RX_CLK);
         rd_addr = `ETH_RX_BUF_ADDR_W'(i);
         #10;
         check($sformatf("rd_data[%0d]", i), 32'(rd_data), 32'(q[i]));
      end
   endtask

   task automatic ack_frame();
      @(negedge RX_CLK);
      rcv_ack = 1'b1;
      @(negedge RX_CLK);
      rcv_ack = 1'b0;
      check("data_rcvd", 32'(data_rcvd), 32'd0);
   endtask

   task automatic accept_frame(input logic [47:0] dst, input int len);
      build_frame(dst, len);
      send_frame();
      wait_for_rcvd();
      check("rcv_size", 32'(rcv_size), 32'(len));
      check_contents(frame_q);
      ack_frame();
   endtask

   task automatic apply_reset();
      @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b0;
      repeat (16) @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b1;
   endtask

   task automatic test_good_unicast();
      accept_frame(own_mac, 100);
   endtask

   // Reuses the frame left by the previous test
   task automatic test_bad_fcs();
      logic [7:0] drops;
      drops = drop_count;
      frame_q[frame_q.size() - 1] = frame_q[frame_q.size() - 1] ^ 8'h10;
      send_frame();
      expect_no_frame();
      check("drop_count", 32'(drop_count), 32'(drops));
   endtask

   task automatic test_address_filter();
      build_frame(other_mac, 80);
      send_frame();
      expect_no_frame();
      accept_frame(bcast_mac, 80);
   endtask

   task automatic test_runt();
      build_frame(own_mac, 60);
      send_frame();
      expect_no_frame();
      accept_frame(own_mac, 64);
   endtask

   task automatic test_occupancy();
      byte_q_t    held_q;
      logic [7:0] drops;
      drops = drop_count;
      build_frame(own_mac, 70);
      send_frame();
      wait_for_rcvd();
      held_q = frame_q;
      // Two frames arrive while the host still owns the buffer
      for (int k = 1; k <= 2; k++) begin
         build_frame(own_mac, 70 + 4 * k);
         send_frame();
         repeat (8) @(negedge RX_CLK);
      end
      check("drop_count", 32'(drop_count), 32'(drops) + 32'd2);
      check("data_rcvd", 32'(data_rcvd), 32'd1);
      check("rcv_size", 32'(rcv_size), 32'd70);
      check_contents(held_q);
      ack_frame();
      accept_frame(own_mac, 90);
   endtask

   task automatic test_reset_and_abort();
      apply_reset();
      @(negedge RX_CLK);
      check("data_rcvd", 32'(data_rcvd), 32'd0);
      check("rcv_size", 32'(rcv_size), 32'd0);
      check("drop_count", 32'(drop_count), 32'd0);
      check("phy_dv_detected", 32'(phy_dv_detected), 32'd0);
      // Preamble cut short before any SFD
      repeat (6) drive_nibble(4'h5);
      @(negedge RX_CLK);
      rx_dv = 1'b0;
      expect_no_frame();
      check("phy_dv_detected", 32'(phy_dv_detected), 32'd1);
   endtask

   initial begin
      #(watchdog_ns);
      report_failure("watchdog expired before the tests finished");
   end

   initial begin
      ETH_PHY_RESETN = 1'b0;
      rx_data        = 4'h0;
      rx_dv          = 1'b0;
      rcv_ack        = 1'b0;
      rd_addr        = '0;
      apply_reset();
      test_good_unicast();
      test_bad_fcs();
      test_address_filter();
      test_runt();
      test_occupancy();
      test_reset_and_abort();
      repeat (2) @(negedge RX_CLK);
      if (UUT.bus_checks.violation) begin
         report_failure("a bound assertion fired during the run");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

// File: eth_rx_top.sv
`timescale 1ns/1ps

`include "eth_rx_settings.svh"

module eth_rx_top (
   input  logic                            RX_CLK,
   input  logic                            ETH_PHY_RESETN,
   input  logic [3:0]                      rx_data,
   input  logic                            rx_dv,
   input  logic                            rcv_ack,
   input  logic [`ETH_RX_BUF_ADDR_W-1:0]   rd_addr,
   output eth_rx_pkg::rx_byte_t            rd_data,
   output logic                            data_rcvd,
   output eth_rx_pkg::frame_size_t         rcv_size,
   output logic [7:0]                      drop_count,
   output logic                            phy_dv_detected
);
   import eth_rx_pkg::*;

   // Decode to execute
   eth_rx_byte_if dec_bus ();
   // Execute to result
   eth_rx_byte_if chk_bus ();

   verdict_t chk_verdict;

   eth_rx_nibble_decode decode (
      .RX_CLK          (RX_CLK),
      .ETH_PHY_RESETN  (ETH_PHY_RESETN),
      .rx_data         (rx_data),
      .rx_dv           (rx_dv),
      .phy_dv_detected (phy_dv_detected),
      .bus             (dec_bus.sender)
   );

   eth_rx_frame_check check (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .in_bus         (dec_bus.receiver),
      .out_bus        (chk_bus.sender),
      .verdict        (chk_verdict)
   );

   // Verdict is valid with chk_bus.stop
   eth_rx_frame_buffer result (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .bus            (chk_bus.receiver),
      .verdict        (chk_verdict),
      .rcv_ack        (rcv_ack),
      .rd_addr        (rd_addr),
      .rd_data        (rd_data),
      .data_rcvd      (data_rcvd),
      .rcv_size       (rcv_size),
      .drop_count     (drop_count)
   );

endmodule
